// ==== all.f ====
+incdir+include
design/score_pkg.sv
design/bcdDigitCounter.sv
design/sevenSegDecoder.sv
design/scoreControl.sv
design/digitRenderer.sv
design/score.sv
testbench/score_checker.sv
testbench/score_tb.sv

// ==== design/bcdDigitCounter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "score_macros.svh"

module bcdDigitCounter (
    input  logic       clk,
    input  logic       arstN,
    input  logic       increment,
    input  logic       clear,
    output logic [3:0] digit,
    output logic       carry
);

    logic atMax;

    assign atMax = (digit == 4'(`SCORE_MAX_DIGIT));

    // combinational so the whole chain ripples within one edge
    assign carry = increment && atMax;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            digit <= 4'd0;
        end else if (clear) begin
            digit <= 4'd0;
        end else if (increment) begin
            if (atMax) begin
                digit <= 4'd0;
            end else begin
                digit <= digit + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/digitRenderer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "score_macros.svh"

module digitRenderer (
    input  logic                    clk,
    input  logic                    arstN,
    input  score_pkg::pixelPos_t    pixel,
    input  score_pkg::scoreDigits_t digits,
    output logic                    drawRequest
);
    import score_pkg::*;

    localparam int ColW = $clog2(`SCORE_DIGIT_W);
    localparam int RowW = $clog2(`SCORE_DIGIT_H);

    // index 0 is the ones box, same order as the seven-segment outputs
    localparam logic [10:0] boxLeft [3] = '{
        11'(`SCORE_ONES_X),
        11'(`SCORE_TENS_X),
        11'(`SCORE_HUNDREDS_X)
    };
    localparam logic [10:0] boxTop = 11'(`SCORE_TOP_Y);

    logic [3:0]      boxDigit [3];
    logic            insideBox;
    logic [ColW-1:0] colOffset;
    logic [RowW-1:0] rowOffset;
    logic [3:0]      selDigit;
    logic [5:0]      glyphRow;
    logic            glyphBit;

    assign boxDigit[0] = digits.ones;
    assign boxDigit[1] = digits.tens;
    assign boxDigit[2] = digits.hundreds;

    // boxes never overlap, so at most one of them matches
    always_comb begin
        logic [10:0] dx;
        logic [10:0] dy;
        insideBox = 1'b0;
        colOffset = '0;
        rowOffset = '0;
        selDigit  = 4'd0;
        dy = pixel.y - boxTop;
        for (int j = 0; j < 3; j++) begin
            dx = pixel.x - boxLeft[j];
            if ((pixel.x >= boxLeft[j]) &&
                (pixel.x < boxLeft[j] + 11'(`SCORE_DIGIT_W)) &&
                (pixel.y >= boxTop) &&
                (pixel.y < boxTop + 11'(`SCORE_DIGIT_H))) begin
                insideBox = 1'b1;
                colOffset = dx[ColW-1:0];
                rowOffset = dy[RowW-1:0];
                selDigit  = boxDigit[j];
            end
        end
    end

    always_comb begin
        glyphRow = 6'd0;
        if (insideBox && (selDigit < 4'd10)) begin
            glyphRow = digitGlyph[selDigit][rowOffset];
        end
        // column 0 sits at bit 5
        glyphBit = glyphRow[3'(`SCORE_DIGIT_W - 1) - 3'(colOffset)];
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            drawRequest <= 1'b0;
        end else begin
            drawRequest <= insideBox && glyphBit;
        end
    end

endmodule

`default_nettype wire

// ==== design/score.sv ====
`timescale 1ns/1ns
`default_nettype none

module score (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    monsterDiedPulse,
    input  logic                    gameOverPulse,
    input  logic                    newGamePulse,
    input  score_pkg::pixelPos_t    pixel,
    output logic                    scoreDR,
    output logic [2:0][6:0]         ss,
    output score_pkg::scoreDigits_t digits
);

    logic       countPulse;
    logic       clearPulse;
    logic       onesCarry;
    logic       tensCarry;
    logic [3:0] onesDigit;
    logic [3:0] tensDigit;
    logic [3:0] hundredsDigit;

    assign digits = {hundredsDigit, tensDigit, onesDigit};

    scoreControl i_scoreControl (
        .clk              (clk),
        .arstN            (arstN),
        .monsterDiedPulse (monsterDiedPulse),
        .gameOverPulse    (gameOverPulse),
        .newGamePulse     (newGamePulse),
        .digits           (digits),
        .countPulse       (countPulse),
        .clearPulse       (clearPulse)
    );

    // ones -> tens -> hundreds, carries ripple in the same cycle
    bcdDigitCounter i_onesCounter (
        .clk       (clk),
        .arstN     (arstN),
        .increment (countPulse),
        .clear     (clearPulse),
        .digit     (onesDigit),
        .carry     (onesCarry)
    );

    bcdDigitCounter i_tensCounter (
        .clk       (clk),
        .arstN     (arstN),
        .increment (onesCarry),
        .clear     (clearPulse),
        .digit     (tensDigit),
        .carry     (tensCarry)
    );

    // the controller keeps 999 from ever counting, so this carry stays open
    bcdDigitCounter i_hundredsCounter (
        .clk       (clk),
        .arstN     (arstN),
        .increment (tensCarry),
        .clear     (clearPulse),
        .digit     (hundredsDigit),
        .carry     ()
    );

    sevenSegDecoder i_onesSs (
        .digit (onesDigit),
        .ss    (ss[0])
    );

    sevenSegDecoder i_tensSs (
        .digit (tensDigit),
        .ss    (ss[1])
    );

    sevenSegDecoder i_hundredsSs (
        .digit (hundredsDigit),
        .ss    (ss[2])
    );

    digitRenderer i_digitRenderer (
        .clk         (clk),
        .arstN       (arstN),
        .pixel       (pixel),
        .digits      (digits),
        .drawRequest (scoreDR)
    );

endmodule

`default_nettype wire

// ==== design/scoreControl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "score_macros.svh"

module scoreControl (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    monsterDiedPulse,
    input  logic                    gameOverPulse,
    input  logic                    newGamePulse,
    input  score_pkg::scoreDigits_t digits,
    output logic                    countPulse,
    output logic                    clearPulse
);
    import score_pkg::*;

    ctrlState_e state;
    ctrlState_e nextState;
    logic       atMax;
    logic       almostMax;
    logic       saturated;
    logic       countNext;

    assign atMax = (digits.hundreds == 4'(`SCORE_MAX_DIGIT)) &&
                   (digits.tens == 4'(`SCORE_MAX_DIGIT)) &&
                   (digits.ones == 4'(`SCORE_MAX_DIGIT));

    assign almostMax = (digits.hundreds == 4'(`SCORE_MAX_DIGIT)) &&
                       (digits.tens == 4'(`SCORE_MAX_DIGIT)) &&
                       (digits.ones == 4'(`SCORE_MAX_DIGIT - 1));

    // a count still in flight from 998 already fills the score,
    // while a pending clear means the digits are about to drop to 000
    assign saturated = (atMax || (countPulse && almostMax)) && !clearPulse;

    // new game overrides everything else in the same cycle
    always_comb begin
        nextState = state;
        if (newGamePulse) begin
            nextState = ePlay;
        end else if (gameOverPulse) begin
            nextState = eFrozen;
        end
    end

    assign countNext = monsterDiedPulse && !newGamePulse && (state == ePlay) && !saturated;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= ePlay;
            countPulse <= 1'b0;
            clearPulse <= 1'b0;
        end else begin
            state      <= nextState;
            countPulse <= countNext;
            clearPulse <= newGamePulse;
        end
    end

endmodule

`default_nettype wire

// ==== design/score_pkg.sv ====
`default_nettype none

package score_pkg;

    typedef struct packed {
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } scoreDigits_t;

    typedef struct packed {
        logic [10:0] x;
        logic [10:0] y;
    } pixelPos_t;

    typedef enum logic {
        ePlay,
        eFrozen
    } ctrlState_e;

    // one line per digit, row 0 first, bit 5 is the leftmost column
    localparam logic [5:0] digitGlyph [10][10] = '{
        '{6'h1E, 6'h33, 6'h33, 6'h37, 6'h3B, 6'h33, 6'h33, 6'h33, 6'h1E, 6'h00},
        '{6'h0C, 6'h1C, 6'h3C, 6'h0C, 6'h0C, 6'h0C, 6'h0C, 6'h0C, 6'h3F, 6'h00},
        '{6'h1E, 6'h33, 6'h03, 6'h06, 6'h0C, 6'h18, 6'h30, 6'h30, 6'h3F, 6'h00},
        '{6'h1E, 6'h33, 6'h03, 6'h03, 6'h0E, 6'h03, 6'h03, 6'h33, 6'h1E, 6'h00},
        '{6'h06, 6'h0E, 6'h1E, 6'h36, 6'h36, 6'h3F, 6'h06, 6'h06, 6'h06, 6'h00},
        '{6'h3F, 6'h30, 6'h30, 6'h3E, 6'h03, 6'h03, 6'h03, 6'h33, 6'h1E, 6'h00},
        '{6'h1E, 6'h33, 6'h30, 6'h3E, 6'h33, 6'h33, 6'h33, 6'h33, 6'h1E, 6'h00},
        '{6'h3F, 6'h03, 6'h03, 6'h06, 6'h0C, 6'h18, 6'h18, 6'h18, 6'h18, 6'h00},
        '{6'h1E, 6'h33, 6'h33, 6'h33, 6'h1E, 6'h33, 6'h33, 6'h33, 6'h1E, 6'h00},
        '{6'h1E, 6'h33, 6'h33, 6'h33, 6'h1F, 6'h03, 6'h03, 6'h33, 6'h1E, 6'h00}
    };

    // active low, bit 0 is segment a, bit 6 is segment g
    localparam logic [6:0] segPattern [10] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
        7'h12, 7'h02, 7'h78, 7'h00, 7'h10
    };

endpackage

`default_nettype wire

// ==== design/sevenSegDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module sevenSegDecoder (
    input  logic [3:0] digit,
    output logic [6:0] ss
);
    import score_pkg::*;

    always_comb begin
        if (digit < 4'd10) begin
            ss = segPattern[digit];
        end else begin
            // not a decimal code, blank the display
            ss = 7'h7F;
        end
    end

endmodule

`default_nettype wire

// ==== include/score_macros.svh ====
`ifndef SCORE_MACROS_SVH
`define SCORE_MACROS_SVH

// size of one glyph box in pixels
`define SCORE_DIGIT_W 6
`define SCORE_DIGIT_H 10

// top row shared by all three boxes
`define SCORE_TOP_Y 466

// left column of each box, hundreds leftmost
`define SCORE_ONES_X 600
`define SCORE_TENS_X 590
`define SCORE_HUNDREDS_X 580

// largest value a decimal digit can hold
`define SCORE_MAX_DIGIT 9

`endif

// ==== run.sh ====
#!/bin/sh
# build and run the score testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -f all.f \
    --top-module score_tb -o score_sim \
    && ./obj_dir/score_sim > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"

// ==== testbench/score_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module score_checker (
    input logic                  clk,
    input logic                  arstN,
    input score_pkg::ctrlState_e state,
    input logic                  monsterDiedPulse,
    input logic                  newGamePulse,
    input logic                  countPulse,
    input logic                  clearPulse
);
    import score_pkg::*;

    // a count and a clear never leave the controller together
    pulsesExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(countPulse && clearPulse))
        else $error("countPulse and clearPulse high in the same cycle");

    // a pulse only follows the edge that sampled its event, so one event gives one cycle
    countOneCycle: assert property (@(posedge clk) disable iff (!arstN)
        countPulse |-> $past(monsterDiedPulse))
        else $error("countPulse high without a monster pulse on the edge before");

    clearOneCycle: assert property (@(posedge clk) disable iff (!arstN)
        clearPulse |-> $past(newGamePulse))
        else $error("clearPulse high without a new-game pulse on the edge before");

    // a frozen controller launches no count on the following edge
    noCountWhenFrozen: assert property (@(posedge clk) disable iff (!arstN)
        (state == eFrozen) |=> !countPulse)
        else $error("countPulse raised while frozen");

endmodule

`default_nettype wire

// ==== testbench/score_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "score_macros.svh"

module score_tb;
    import score_pkg::*;

    localparam int ScoreTimeout = 8;

    logic         clk = 1'b0;
    logic         arstN;
    logic         monsterDiedPulse;
    logic         gameOverPulse;
    logic         newGamePulse;
    pixelPos_t    pixel;
    logic         scoreDR;
    logic [2:0][6:0] ss;
    scoreDigits_t digits;

    int modelScore;
    int errorCount;
    int checkCount;
    int testStartErrors;
    int randomPulses;

    score i_score (
        .clk              (clk),
        .arstN            (arstN),
        .monsterDiedPulse (monsterDiedPulse),
        .gameOverPulse    (gameOverPulse),
        .newGamePulse     (newGamePulse),
        .pixel            (pixel),
        .scoreDR          (scoreDR),
        .ss               (ss),
        .digits           (digits)
    );

    bind scoreControl score_checker i_scoreChecker (
        .clk              (clk),
        .arstN            (arstN),
        .state            (state),
        .monsterDiedPulse (monsterDiedPulse),
        .newGamePulse     (newGamePulse),
        .countPulse       (countPulse),
        .clearPulse       (clearPulse)
    );

    always #5 clk = ~clk;

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic scoreDigits_t expectedDigits();
        scoreDigits_t d;
        d.hundreds = 4'(modelScore / 100);
        d.tens     = 4'((modelScore / 10) % 10);
        d.ones     = 4'(modelScore % 10);
        return d;
    endfunction

    // glyph bit of whichever box covers (x, y), low outside all boxes
    function automatic logic expectedDraw(int x, int y);
        int         lefts [3];
        int         values [3];
        logic [5:0] rowBits;
        logic       result;
        lefts[0]  = `SCORE_ONES_X;
        lefts[1]  = `SCORE_TENS_X;
        lefts[2]  = `SCORE_HUNDREDS_X;
        values[0] = modelScore % 10;
        values[1] = (modelScore / 10) % 10;
        values[2] = modelScore / 100;
        result = 1'b0;
        for (int b = 0; b < 3; b++) begin
            if ((x >= lefts[b]) && (x < lefts[b] + `SCORE_DIGIT_W) &&
                (y >= `SCORE_TOP_Y) && (y < `SCORE_TOP_Y + `SCORE_DIGIT_H)) begin
                rowBits = digitGlyph[4'(values[b])][4'(y - `SCORE_TOP_Y)];
                result  = rowBits[3'(`SCORE_DIGIT_W - 1 - (x - lefts[b]))];
            end
        end
        return result;
    endfunction

    task automatic reportValue(string name, logic [31:0] expected, logic [31:0] actual);
        $display("error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic checkOutputs();
        scoreDigits_t exp;
        exp = expectedDigits();
        checkCount++;
        if (digits !== exp) begin
            reportValue("digits", {20'd0, exp}, {20'd0, digits});
        end
        if (ss[0] !== segPattern[exp.ones]) begin
            reportValue("ss[0]", {25'd0, segPattern[exp.ones]}, {25'd0, ss[0]});
        end
        if (ss[1] !== segPattern[exp.tens]) begin
            reportValue("ss[1]", {25'd0, segPattern[exp.tens]}, {25'd0, ss[1]});
        end
        if (ss[2] !== segPattern[exp.hundreds]) begin
            reportValue("ss[2]", {25'd0, segPattern[exp.hundreds]}, {25'd0, ss[2]});
        end
    endtask

    task automatic waitForScore();
        scoreDigits_t exp;
        int           cycles;
        exp = expectedDigits();
        cycles = 0;
        while ((digits !== exp) && (cycles < ScoreTimeout)) begin
            tick();
            cycles++;
        end
        if (digits !== exp) begin
            $display("timeout at %0t ns: score did not reach %03h within %0d cycles",
                     $time, exp, ScoreTimeout);
            errorCount++;
        end
    endtask

    task automatic pulseInputs(logic monster, logic gameOver, logic newGame);
        monsterDiedPulse = monster;
        gameOverPulse    = gameOver;
        newGamePulse     = newGame;
        tick();
        monsterDiedPulse = 1'b0;
        gameOverPulse    = 1'b0;
        newGamePulse     = 1'b0;
    endtask

    // score must sit still for a few edges
    task automatic holdScore(int cycles);
        repeat (cycles) begin
            tick();
            checkOutputs();
        end
    endtask

    task automatic countUp();
        pulseInputs(1'b1, 1'b0, 1'b0);
        modelScore++;
        waitForScore();
        checkOutputs();
    endtask

    task automatic countTo(int target);
        while (modelScore < target) begin
            countUp();
        end
    endtask

    task automatic ignoredPulse();
        pulseInputs(1'b1, 1'b0, 1'b0);
        holdScore(4);
    endtask

    task automatic clearScore();
        pulseInputs(1'b0, 1'b0, 1'b1);
        modelScore = 0;
        waitForScore();
        checkOutputs();
    endtask

    // one pixel per cycle over each box and a one-pixel margin around it
    task automatic scanBoxes();
        int   lefts [3];
        logic expected;
        lefts[0] = `SCORE_ONES_X;
        lefts[1] = `SCORE_TENS_X;
        lefts[2] = `SCORE_HUNDREDS_X;
        for (int b = 0; b < 3; b++) begin
            for (int y = `SCORE_TOP_Y - 1; y <= `SCORE_TOP_Y + `SCORE_DIGIT_H; y++) begin
                for (int x = lefts[b] - 1; x <= lefts[b] + `SCORE_DIGIT_W; x++) begin
                    pixel.x = 11'(x);
                    pixel.y = 11'(y);
                    tick();
                    expected = expectedDraw(x, y);
                    checkCount++;
                    if (scoreDR !== expected) begin
                        $display("error at %0t ns: scoreDR at (%0d,%0d) expected %0b got %0b",
                                 $time, x, y, expected, scoreDR);
                        errorCount++;
                    end
                end
            end
        end
        pixel = '0;
    endtask

    task automatic startTest();
        testStartErrors = errorCount;
    endtask

    task automatic finishTest(string name);
        if (errorCount == testStartErrors) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errorCount - testStartErrors);
        end
    endtask

    task automatic resetAndSingleCount();
        startTest();
        checkOutputs();
        pulseInputs(1'b1, 1'b0, 1'b0);
        // one edge after the sampling edge the digits have not moved yet
        checkCount++;
        if (digits !== 12'h000) begin
            reportValue("digits", 32'h0, {20'd0, digits});
        end
        tick();
        modelScore = 1;
        checkOutputs();
        finishTest("reset and single count");
    endtask

    task automatic randomCount();
        startTest();
        clearScore();
        randomPulses = int'($urandom_range(150, 1));
        repeat (randomPulses) begin
            countUp();
        end
        finishTest($sformatf("count of %0d pulses", randomPulses));
    endtask

    task automatic freezeAndNewGame();
        startTest();
        clearScore();
        repeat (3) countUp();
        pulseInputs(1'b0, 1'b1, 1'b0);
        repeat (3) ignoredPulse();
        clearScore();
        repeat (2) countUp();
        // new game wins over a monster in the same cycle
        pulseInputs(1'b1, 1'b0, 1'b1);
        modelScore = 0;
        waitForScore();
        holdScore(4);
        finishTest("freeze and new game");
    endtask

    task automatic glyphScan();
        int targets [4];
        startTest();
        targets = '{120, 345, 678, 999};
        foreach (targets[i]) begin
            countTo(targets[i]);
            scanBoxes();
        end
        finishTest("glyph scan");
    endtask

    task automatic saturation();
        startTest();
        countTo(999);
        repeat (5) ignoredPulse();
        finishTest("saturation at 999");
    endtask

    initial begin
        void'($urandom(45192));
        arstN            = 1'b0;
        monsterDiedPulse = 1'b0;
        gameOverPulse    = 1'b0;
        newGamePulse     = 1'b0;
        pixel            = '0;
        modelScore       = 0;
        errorCount       = 0;
        checkCount       = 0;
        testStartErrors  = 0;
        randomPulses     = 0;
        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;

        resetAndSingleCount();
        randomCount();
        freezeAndNewGame();
        glyphScan();
        saturation();

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
